//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_bch_decoder
FLIST     = flist.f

OBJ_DIR = obj_dir
SIM     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(shell grep -v '^+' $(FLIST)) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@! grep -q "TEST FAILED" $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bch_berlekamp.sv
`include "bch_defines.svh"

module bch_berlekamp (
	input                      clk,
	input                      rstn,
	input                      i_syn_valid,
	output                     o_syn_accept,
	input  bch_pkg::syn_t      i_syn,
	output                     o_loc_valid,
	input                      i_loc_accept,
	output bch_pkg::locator_t  o_loc
);

	bch_pkg::ber_state_e  state_q;
	logic signed [3:0]    mu_q;
	bch_pkg::syn_t        syn_q;
	logic [`BCH_GF_W-1:0] syn [`BCH_NSYN];
	logic [`BCH_GF_W-1:0] lam_q [`BCH_T + 1];
	logic [`BCH_GF_W-1:0] lam_rho_q [`BCH_T + 1];
	logic [`BCH_GF_W-1:0] lam_d [`BCH_T + 1];
	logic [`BCH_GF_W-1:0] d_q;
	logic [`BCH_GF_W-1:0] d_rho_q;
	logic [`BCH_GF_W-1:0] d_next;
	logic signed [3:0]    l_q;
	logic signed [3:0]    l_rho_q;
	logic signed [3:0]    l_d;
	logic signed [3:0]    rho_q;
	logic                 upd_rho;

	assign syn[0] = syn_q.s1;
	assign syn[1] = syn_q.s2;
	assign syn[2] = syn_q.s3;
	assign syn[3] = syn_q.s4;

	// inversionless update lambda' = d_rho * lambda + d * x^(mu - rho) * lambda_rho
	always_comb begin
		int shift;
		int sidx;
		logic signed [3:0] l_alt;
		shift = int'(mu_q - rho_q);
		l_alt = l_rho_q + mu_q - rho_q;
		for (int i = 0; i <= `BCH_T; i++) begin
			lam_d[i] = lam_q[i];
			if (d_q != '0) begin
				lam_d[i] = bch_pkg::gf_mul(syn_q.code, d_rho_q, lam_q[i]);
				if (i >= shift) begin
					lam_d[i] = lam_d[i] ^ bch_pkg::gf_mul(syn_q.code, d_q, lam_rho_q[i - shift]);
				end
			end
		end
		l_d = (d_q != '0 && l_alt > l_q) ? l_alt : l_q;
		upd_rho = (d_q != '0) && ((mu_q - l_q) > (rho_q - l_rho_q));
		// next discrepancy from S_(mu+2) downward
		d_next = '0;
		for (int i = 0; i <= `BCH_T; i++) begin
			sidx = int'(mu_q) + 2 - i;
			if (i <= int'(l_d) && sidx >= 1 && sidx <= `BCH_NSYN) begin
				d_next = d_next ^ bch_pkg::gf_mul(syn_q.code, lam_d[i], syn[sidx - 1]);
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= bch_pkg::BER_IDLE;
			mu_q <= '0;
		end else begin
			case (state_q)
				bch_pkg::BER_IDLE: begin
					mu_q <= '0;
					if (i_syn_valid) begin
						state_q <= bch_pkg::BER_RUN;
					end
				end
				bch_pkg::BER_RUN: begin
					mu_q <= mu_q + 4'sd1;
					if (mu_q == 4'sd3) begin
						state_q <= bch_pkg::BER_HOLD;
					end
				end
				bch_pkg::BER_HOLD: begin
					if (i_loc_accept) begin
						state_q <= bch_pkg::BER_IDLE;
					end
				end
				default: state_q <= bch_pkg::BER_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == bch_pkg::BER_IDLE && i_syn_valid) begin
			syn_q <= i_syn;
			for (int i = 0; i <= `BCH_T; i++) begin
				lam_q[i] <= (i == 0) ? 8'h01 : 8'h00;
				lam_rho_q[i] <= (i == 0) ? 8'h01 : 8'h00;
			end
			d_q <= i_syn.s1;
			d_rho_q <= 8'h01;
			l_q <= '0;
			l_rho_q <= '0;
			rho_q <= -4'sd1;
		end else if (state_q == bch_pkg::BER_RUN) begin
			lam_q <= lam_d;
			l_q <= l_d;
			d_q <= d_next;
			if (upd_rho) begin
				rho_q <= mu_q;
				l_rho_q <= l_q;
				d_rho_q <= d_q;
				lam_rho_q <= lam_q;
			end
		end
	end

	assign o_syn_accept = (state_q == bch_pkg::BER_IDLE) && i_syn_valid;
	assign o_loc_valid = (state_q == bch_pkg::BER_HOLD);
	assign o_loc = '{code: syn_q.code, lambda0: lam_q[0], lambda1: lam_q[1], lambda2: lam_q[2]};

	// three or more errors would push the length past what is stored
	a_loc_degree: assert property (@(posedge clk) disable iff (!rstn)
		$rose(o_loc_valid) |-> (l_q <= `BCH_T));

endmodule

//--- bch_chien.sv
`include "bch_defines.svh"

module bch_chien (
	input                      clk,
	input                      rstn,
	input                      i_loc_valid,
	output                     o_loc_accept,
	input  bch_pkg::locator_t  i_loc,
	output                     o_finish,
	output [`BCH_POS_W-1:0]    o_odata
);

	bch_pkg::chien_state_e state_q;
	bch_pkg::locator_t     loc_q;
	logic [1:0]            found_q;
	logic [1:0]            found_d;
	logic                  out_idx_q;
	logic [8:0]            base_q;
	logic [8:0]            n_pos;
	logic [`BCH_GF_W-1:0]  a_inv8;
	logic [`BCH_GF_W-1:0]  power_q [`BCH_CHIEN_PAR];
	logic [`BCH_GF_W-1:0]  pw_init [`BCH_CHIEN_PAR];
	logic [`BCH_POS_W-1:0] slot_q [`BCH_T];
	logic [`BCH_POS_W-1:0] slot_d [`BCH_T];

	assign n_pos = (loc_q.code == bch_pkg::CODE_63) ? 9'd63 : 9'd255;
	assign a_inv8 = (loc_q.code == bch_pkg::CODE_63) ? bch_pkg::ALPHA_INV8_63 :
		bch_pkg::ALPHA_INV8_255;

	// alpha^0 .. alpha^-7 for the first group
	always_comb begin
		logic [`BCH_GF_W-1:0] p;
		logic [`BCH_GF_W-1:0] a_inv1;
		a_inv1 = (i_loc.code == bch_pkg::CODE_63) ? bch_pkg::ALPHA_INV1_63 :
			bch_pkg::ALPHA_INV1_255;
		p = 8'h01;
		for (int k = 0; k < `BCH_CHIEN_PAR; k++) begin
			pw_init[k] = p;
			p = bch_pkg::gf_mul(i_loc.code, p, a_inv1);
		end
	end

	// position base+k is an error when lambda(alpha^-(base+k)) == 0
	always_comb begin
		logic [`BCH_GF_W-1:0] p2;
		logic [`BCH_GF_W-1:0] eval;
		logic [8:0]           pos;
		found_d = found_q;
		slot_d = slot_q;
		for (int k = 0; k < `BCH_CHIEN_PAR; k++) begin
			pos = base_q + 9'(k);
			p2 = bch_pkg::gf_mul(loc_q.code, power_q[k], power_q[k]);
			eval = loc_q.lambda0 ^ bch_pkg::gf_mul(loc_q.code, power_q[k], loc_q.lambda1) ^
				bch_pkg::gf_mul(loc_q.code, p2, loc_q.lambda2);
			if (eval == '0 && pos < n_pos && found_d < 2'(`BCH_T)) begin
				slot_d[found_d[0]] = pos[`BCH_POS_W-1:0];
				found_d = found_d + 2'd1;
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= bch_pkg::CHI_IDLE;
			found_q <= '0;
			out_idx_q <= 1'b0;
		end else begin
			case (state_q)
				bch_pkg::CHI_IDLE: begin
					found_q <= '0;
					if (i_loc_valid) begin
						state_q <= bch_pkg::CHI_SEARCH;
					end
				end
				bch_pkg::CHI_SEARCH: begin
					found_q <= found_d;
					out_idx_q <= 1'b0;
					// stop on two roots or once the group holding position n is tested
					if (found_d == 2'(`BCH_T) || base_q + `BCH_CHIEN_PAR > n_pos) begin
						state_q <= bch_pkg::CHI_OUT;
					end
				end
				bch_pkg::CHI_OUT: begin
					out_idx_q <= ~out_idx_q;
					if (out_idx_q) begin
						state_q <= bch_pkg::CHI_IDLE;
					end
				end
				default: state_q <= bch_pkg::CHI_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == bch_pkg::CHI_IDLE && i_loc_valid) begin
			loc_q <= i_loc;
			base_q <= '0;
			power_q <= pw_init;
			for (int s = 0; s < `BCH_T; s++) begin
				slot_q[s] <= `BCH_POS_W'(`BCH_NO_POS);
			end
		end else if (state_q == bch_pkg::CHI_SEARCH) begin
			base_q <= base_q + `BCH_CHIEN_PAR;
			slot_q <= slot_d;
			for (int k = 0; k < `BCH_CHIEN_PAR; k++) begin
				power_q[k] <= bch_pkg::gf_mul(loc_q.code, power_q[k], a_inv8);
			end
		end
	end

	assign o_loc_accept = (state_q == bch_pkg::CHI_IDLE) && i_loc_valid;
	assign o_finish = (state_q == bch_pkg::CHI_OUT);
	assign o_odata = o_finish ? slot_q[out_idx_q] : '0;

	a_finish_len: assert property (@(posedge clk) disable iff (!rstn)
		$rose(o_finish) |=> o_finish ##1 !o_finish);

endmodule

//--- bch_decoder.sv
`include "bch_defines.svh"

module bch_decoder (
	input                      clk,
	input                      rstn,
	input                      i_set,
	input  bch_pkg::code_e     i_code,
	input  [`BCH_WORD_W-1:0]   i_data,
	output                     o_ready,
	output                     o_finish,
	output [`BCH_POS_W-1:0]    o_odata
);

	logic              syn_valid;
	logic              syn_accept;
	bch_pkg::syn_t     syn;
	logic              loc_valid;
	logic              loc_accept;
	bch_pkg::locator_t loc;

	// syndromes are folded in while the frame streams in
	bch_syndrome u_syndrome (
		.clk          (clk),
		.rstn         (rstn),
		.i_set        (i_set),
		.i_code       (i_code),
		.i_data       (i_data),
		.o_ready      (o_ready),
		.o_syn_valid  (syn_valid),
		.i_syn_accept (syn_accept),
		.o_syn        (syn)
	);

	bch_berlekamp u_berlekamp (
		.clk          (clk),
		.rstn         (rstn),
		.i_syn_valid  (syn_valid),
		.o_syn_accept (syn_accept),
		.i_syn        (syn),
		.o_loc_valid  (loc_valid),
		.i_loc_accept (loc_accept),
		.o_loc        (loc)
	);

	bch_chien u_chien (
		.clk          (clk),
		.rstn         (rstn),
		.i_loc_valid  (loc_valid),
		.o_loc_accept (loc_accept),
		.i_loc        (loc),
		.o_finish     (o_finish),
		.o_odata      (o_odata)
	);

endmodule

//--- bch_defines.svh
`ifndef BCH_DEFINES_SVH
`define BCH_DEFINES_SVH

// width of one field element, wide enough for GF(2^8)
`define BCH_GF_W 8

// received bits per input word
`define BCH_WORD_W 8

// syndromes S1..S4
`define BCH_NSYN 4

// correctable errors per frame
`define BCH_T 2

// positions evaluated per chien cycle
`define BCH_CHIEN_PAR 8

// error position width on the output
`define BCH_POS_W 8

// marker for an unused output slot
`define BCH_NO_POS 255

`endif

//--- bch_pkg.sv
`include "bch_defines.svh"

package bch_pkg;

	typedef enum logic [1:0] {
		CODE_63  = 2'd1,
		CODE_255 = 2'd2
	} code_e;

	typedef enum logic [1:0] {
		SYN_IDLE,
		SYN_LOAD,
		SYN_HOLD
	} syn_state_e;

	typedef enum logic [1:0] {
		BER_IDLE,
		BER_RUN,
		BER_HOLD
	} ber_state_e;

	typedef enum logic [1:0] {
		CHI_IDLE,
		CHI_SEARCH,
		CHI_OUT
	} chien_state_e;

	typedef struct packed {
		code_e                code;
		logic [`BCH_GF_W-1:0] s1;
		logic [`BCH_GF_W-1:0] s2;
		logic [`BCH_GF_W-1:0] s3;
		logic [`BCH_GF_W-1:0] s4;
	} syn_t;

	typedef struct packed {
		code_e                code;
		logic [`BCH_GF_W-1:0] lambda0;
		logic [`BCH_GF_W-1:0] lambda1;
		logic [`BCH_GF_W-1:0] lambda2;
	} locator_t;

	// alpha^-1 and alpha^-8 in each field
	localparam logic [`BCH_GF_W-1:0] ALPHA_INV1_63  = 8'h21;
	localparam logic [`BCH_GF_W-1:0] ALPHA_INV8_63  = 8'h2e;
	localparam logic [`BCH_GF_W-1:0] ALPHA_INV1_255 = 8'h8e;
	localparam logic [`BCH_GF_W-1:0] ALPHA_INV8_255 = 8'h83;

	// field polynomials including the x^m term
	localparam logic [`BCH_GF_W:0] POLY_63  = 9'h043;
	localparam logic [`BCH_GF_W:0] POLY_255 = 9'h11d;

	// shift and add multiply, reduced after every shift
	function automatic logic [`BCH_GF_W-1:0] gf_mul(
		input code_e                code,
		input logic [`BCH_GF_W-1:0] a,
		input logic [`BCH_GF_W-1:0] b
	);
		logic [`BCH_GF_W:0]   sh;
		logic [`BCH_GF_W-1:0] acc;
		acc = '0;
		sh = {1'b0, a};
		for (int k = 0; k < `BCH_GF_W; k++) begin
			if (b[k]) begin
				acc = acc ^ sh[`BCH_GF_W-1:0];
			end
			sh = sh << 1;
			if (code == CODE_63 && sh[6]) begin
				sh = sh ^ POLY_63;
			end else if (code != CODE_63 && sh[`BCH_GF_W]) begin
				sh = sh ^ POLY_255;
			end
		end
		return acc;
	endfunction

endpackage

//--- bch_syndrome.sv
`include "bch_defines.svh"

module bch_syndrome (
	input                          clk,
	input                          rstn,
	input                          i_set,
	input  bch_pkg::code_e         i_code,
	input  [`BCH_WORD_W-1:0]       i_data,
	output                         o_ready,
	output                         o_syn_valid,
	input                          i_syn_accept,
	output bch_pkg::syn_t          o_syn
);

	bch_pkg::syn_state_e  state_q;
	logic [4:0]           cnt_q;
	logic [4:0]           last_cnt;
	bch_pkg::syn_t        syn_q;
	logic [`BCH_GF_W-1:0] syn_acc [`BCH_NSYN];

	// 8 words for n = 63, 32 words for n = 255
	assign last_cnt = (syn_q.code == bch_pkg::CODE_63) ? 5'd7 : 5'd31;

	// eight horner steps per syndrome, S_j picks up alpha^j per bit
	always_comb begin
		logic [`BCH_WORD_W-1:0] bits;
		bits = i_data;
		// position n is padding
		if (cnt_q == '0) begin
			bits[`BCH_WORD_W-1] = 1'b0;
		end
		syn_acc[0] = syn_q.s1;
		syn_acc[1] = syn_q.s2;
		syn_acc[2] = syn_q.s3;
		syn_acc[3] = syn_q.s4;
		for (int j = 0; j < `BCH_NSYN; j++) begin
			for (int b = `BCH_WORD_W - 1; b >= 0; b--) begin
				syn_acc[j] = bch_pkg::gf_mul(syn_q.code, syn_acc[j], 8'h02 << j) ^
					{{(`BCH_GF_W - 1){1'b0}}, bits[b]};
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= bch_pkg::SYN_IDLE;
			cnt_q <= '0;
		end else begin
			case (state_q)
				bch_pkg::SYN_IDLE: begin
					cnt_q <= '0;
					if (i_set) begin
						state_q <= bch_pkg::SYN_LOAD;
					end
				end
				bch_pkg::SYN_LOAD: begin
					cnt_q <= cnt_q + 5'd1;
					if (cnt_q == last_cnt) begin
						state_q <= bch_pkg::SYN_HOLD;
					end
				end
				bch_pkg::SYN_HOLD: begin
					if (i_syn_accept) begin
						state_q <= bch_pkg::SYN_IDLE;
					end
				end
				default: state_q <= bch_pkg::SYN_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == bch_pkg::SYN_IDLE && i_set) begin
			syn_q.code <= i_code;
			syn_q.s1 <= '0;
			syn_q.s2 <= '0;
			syn_q.s3 <= '0;
			syn_q.s4 <= '0;
		end else if (state_q == bch_pkg::SYN_LOAD) begin
			syn_q.s1 <= syn_acc[0];
			syn_q.s2 <= syn_acc[1];
			syn_q.s3 <= syn_acc[2];
			syn_q.s4 <= syn_acc[3];
		end
	end

	assign o_ready = (state_q == bch_pkg::SYN_LOAD);
	assign o_syn_valid = (state_q == bch_pkg::SYN_HOLD);
	assign o_syn = syn_q;

	a_syn_stable: assert property (@(posedge clk) disable iff (!rstn)
		o_syn_valid && !i_syn_accept |=> o_syn_valid && $stable(o_syn));

endmodule

//--- flist.f
+incdir+.
bch_pkg.sv
bch_syndrome.sv
bch_berlekamp.sv
bch_chien.sv
bch_decoder.sv
tb_bch_decoder.sv

//--- tb_bch_decoder.sv
`include "bch_defines.svh"

module tb_bch_decoder;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	localparam int N_FRAMES = 12;
	localparam int MAX_WAIT = 200;

	logic                   clk;
	logic                   rstn;
	logic                   i_set;
	bch_pkg::code_e         i_code;
	logic [`BCH_WORD_W-1:0] i_data;
	logic                   o_ready;
	logic                   o_finish;
	logic [`BCH_POS_W-1:0]  o_odata;

	int          err_count;
	int          pass_count;
	int          fail_count;

	bch_decoder u_bch_decoder (
		.clk      (clk),
		.rstn     (rstn),
		.i_set    (i_set),
		.i_code   (i_code),
		.i_data   (i_data),
		.o_ready  (o_ready),
		.o_finish (o_finish),
		.o_odata  (o_odata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int code_n(input bch_pkg::code_e code);
		return (code == bch_pkg::CODE_63) ? 63 : 255;
	endfunction

	function automatic int code_words(input bch_pkg::code_e code);
		return (code_n(code) + 1) / 8;
	endfunction

	// word k of the zero codeword with e0 and e1 flipped
	// a position of -1 flips nothing
	function automatic logic [7:0] frame_word(input bch_pkg::code_e code, input int k,
		input int e0, input int e1);
		logic [7:0] w;
		int         pos;
		w = '0;
		for (int b = 0; b < 8; b++) begin
			pos = code_n(code) - (8 * k + 7 - b);
			if (pos == e0 || pos == e1) begin
				w[b] = 1'b1;
			end
		end
		return w;
	endfunction

	// sorted flips below n with 255 in empty slots
	function automatic int expected_pos(input bch_pkg::code_e code, input int e0, input int e1,
		input int slot);
		int first;
		int second;
		int tmp;
		first = (e0 >= 0 && e0 < code_n(code)) ? e0 : `BCH_NO_POS;
		second = (e1 >= 0 && e1 < code_n(code)) ? e1 : `BCH_NO_POS;
		if (second < first) begin
			tmp = first;
			first = second;
			second = tmp;
		end
		return (slot == 0) ? first : second;
	endfunction

	task automatic report_mismatch(input string name, input string what, input int expected,
		input int actual);
		$display("FAILED %s %s: expected %0d, actual %0d", name, what, expected, actual);
		err_count++;
	endtask

	task automatic send_frame(input bch_pkg::code_e code, input int e0, input int e1,
		output int ready_cycles);
		int wait_cycles;
		ready_cycles = 0;
		wait_cycles = 0;
		@(posedge clk);
		i_set <= 1'b1;
		i_code <= code;
		i_data <= frame_word(code, 0, e0, e1);
		// request stays up while the syndrome stage is still busy
		@(negedge clk);
		while (!o_ready && wait_cycles < MAX_WAIT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!o_ready) begin
			$display("frame of %s was never accepted by the decoder", code.name());
			err_count++;
			@(posedge clk);
			i_set <= 1'b0;
		end else begin
			ready_cycles = 1;
			for (int k = 1; k < code_words(code); k++) begin
				@(posedge clk);
				i_set <= 1'b0;
				i_data <= frame_word(code, k, e0, e1);
				@(negedge clk);
				if (o_ready) begin
					ready_cycles++;
				end
			end
			@(posedge clk);
			i_set <= 1'b0;
			i_data <= '0;
			@(negedge clk);
			if (o_ready) begin
				ready_cycles++;
			end
		end
	endtask

	task automatic collect_result(output int slot0, output int slot1, output int finish_cycles);
		int wait_cycles;
		wait_cycles = 0;
		slot0 = -1;
		slot1 = -1;
		finish_cycles = 0;
		@(negedge clk);
		while (!o_finish && wait_cycles < MAX_WAIT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!o_finish) begin
			$display("no result came out of the decoder within %0d cycles", MAX_WAIT);
			err_count++;
		end else begin
			slot0 = int'(o_odata);
			finish_cycles = 1;
			@(negedge clk);
			if (o_finish) begin
				finish_cycles++;
				slot1 = int'(o_odata);
			end
			@(negedge clk);
			if (o_finish) begin
				finish_cycles++;
			end
		end
	endtask

	task automatic check_result(input string name, input bch_pkg::code_e code, input int e0,
		input int e1, input int ready_cycles, input int slot0, input int slot1,
		input int finish_cycles);
		int exp0;
		int exp1;
		exp0 = expected_pos(code, e0, e1, 0);
		exp1 = expected_pos(code, e0, e1, 1);
		if (ready_cycles != code_words(code)) begin
			report_mismatch(name, "o_ready cycles", code_words(code), ready_cycles);
		end
		if (finish_cycles != 2) begin
			report_mismatch(name, "o_finish cycles", 2, finish_cycles);
		end
		if (slot0 != exp0) begin
			report_mismatch(name, "slot 0", exp0, slot0);
		end
		if (slot1 != exp1) begin
			report_mismatch(name, "slot 1", exp1, slot1);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_count == errs_before) begin
			$display("%s: ok", name);
			pass_count++;
		end else begin
			$display("%s: failed", name);
			fail_count++;
		end
	endtask

	task automatic run_frame(input string name, input bch_pkg::code_e code, input int e0,
		input int e1);
		int errs;
		int ready_cycles;
		int slot0;
		int slot1;
		int finish_cycles;
		errs = err_count;
		send_frame(code, e0, e1, ready_cycles);
		collect_result(slot0, slot1, finish_cycles);
		check_result(name, code, e0, e1, ready_cycles, slot0, slot1, finish_cycles);
		finish_test(name, errs);
	endtask

	task automatic test_reset_state();
		int errs;
		errs = err_count;
		@(negedge clk);
		if (o_ready != 1'b0) begin
			report_mismatch("reset_state", "o_ready", 0, int'(o_ready));
		end
		if (o_finish != 1'b0) begin
			report_mismatch("reset_state", "o_finish", 0, int'(o_finish));
		end
		finish_test("reset_state", errs);
	endtask

	task automatic test_no_error(input bch_pkg::code_e code);
		run_frame($sformatf("no_error_%s", code.name()), code, -1, -1);
	endtask

	task automatic test_single_error(input bch_pkg::code_e code);
		int e0;
		e0 = $urandom_range(code_n(code) - 1, 0);
		run_frame($sformatf("single_error_%s", code.name()), code, e0, -1);
	endtask

	task automatic test_double_error(input bch_pkg::code_e code);
		int e0;
		int e1;
		e0 = $urandom_range(code_n(code) - 1, 0);
		e1 = e0;
		while (e1 == e0) begin
			e1 = $urandom_range(code_n(code) - 1, 0);
		end
		run_frame($sformatf("double_error_%s", code.name()), code, e0, e1);
	endtask

	// lowest and highest data positions
	task automatic test_double_edges(input bch_pkg::code_e code);
		run_frame($sformatf("double_edges_%s", code.name()), code, code_n(code) - 1, 0);
	endtask

	task automatic test_padding_only(input bch_pkg::code_e code);
		run_frame($sformatf("padding_only_%s", code.name()), code, code_n(code), -1);
	endtask

	// second frame loads while the first is in berlekamp or chien
	task automatic test_back_to_back();
		int errs;
		int a0;
		int a1;
		int b0;
		int ready_a;
		int ready_b;
		int s0a;
		int s1a;
		int fin_a;
		int s0b;
		int s1b;
		int fin_b;
		errs = err_count;
		a0 = $urandom_range(127, 0);
		a1 = $urandom_range(254, 128);
		b0 = $urandom_range(62, 0);
		fork
			begin
				send_frame(bch_pkg::CODE_255, a0, a1, ready_a);
				send_frame(bch_pkg::CODE_63, b0, -1, ready_b);
			end
			begin
				collect_result(s0a, s1a, fin_a);
				collect_result(s0b, s1b, fin_b);
			end
		join
		check_result("back_to_back_first", bch_pkg::CODE_255, a0, a1, ready_a, s0a, s1a, fin_a);
		check_result("back_to_back_second", bch_pkg::CODE_63, b0, -1, ready_b, s0b, s1b, fin_b);
		finish_test("back_to_back", errs);
	endtask

	initial begin : watchdog
		#(N_FRAMES * 80 * CLK_PERIOD);
		$display("watchdog expired, the decoder stopped responding before the tests ended");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		i_set = 1'b0;
		i_code = bch_pkg::CODE_63;
		i_data = '0;
		err_count = 0;
		pass_count = 0;
		fail_count = 0;
		void'($urandom(90));
		repeat (10) @(posedge clk);
		rstn <= 1'b1;

		test_reset_state();
		test_no_error(bch_pkg::CODE_63);
		test_no_error(bch_pkg::CODE_255);
		test_single_error(bch_pkg::CODE_63);
		test_single_error(bch_pkg::CODE_255);
		test_double_error(bch_pkg::CODE_63);
		test_double_error(bch_pkg::CODE_255);
		test_double_edges(bch_pkg::CODE_63);
		test_double_edges(bch_pkg::CODE_255);
		test_padding_only(bch_pkg::CODE_63);
		test_padding_only(bch_pkg::CODE_255);
		test_back_to_back();

		$display("summary: %0d tests ok, %0d tests failed, %0d mismatches",
			pass_count, fail_count, err_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
